//--- logic/ooo_core_pkg.sv
`default_nettype none

package ooo_core_pkg;

    // architectural registers, r0 hardwired to zero
    localparam int reg_count     = 32;
    localparam int reg_idx_width = 5;

    // operand and result word
    localparam int data_width = 32;

    // reorder buffer, depth doubles as initial credit count
    localparam int rob_depth     = 8;
    localparam int rob_tag_width = 3;

    // instruction word fields
    localparam int instr_width = 32;
    localparam int op_width    = 4;
    localparam int imm_width   = 14;
    localparam int rform_pad_width = instr_width - op_width - 3 * reg_idx_width;
    localparam int iform_pad_width = instr_width - op_width - 2 * reg_idx_width - imm_width;

    // opcodes, msb set means immediate form
    localparam logic [op_width-1:0] op_add  = 4'h0;
    localparam logic [op_width-1:0] op_sub  = 4'h1;
    localparam logic [op_width-1:0] op_and  = 4'h2;
    localparam logic [op_width-1:0] op_or   = 4'h3;
    localparam logic [op_width-1:0] op_addi = 4'h8;
    localparam logic [op_width-1:0] op_ori  = 4'hb;

    // one word, two decodings
    typedef union packed {
        // register form
        struct packed {
            logic [op_width-1:0]        op;
            logic [reg_idx_width-1:0]   dst;
            logic [reg_idx_width-1:0]   src1;
            logic [reg_idx_width-1:0]   src2;
            logic [rform_pad_width-1:0] pad;
        } reg_form;
        // immediate form, imm in the low bits
        struct packed {
            logic [op_width-1:0]        op;
            logic [reg_idx_width-1:0]   dst;
            logic [reg_idx_width-1:0]   src1;
            logic [iform_pad_width-1:0] pad;
            logic [imm_width-1:0]       imm;
        } imm_form;
    } instr_word_t;

endpackage

`default_nettype wire

//--- logic/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file import ooo_core_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    // source reads from rename
    input  logic [reg_idx_width-1:0] rd_idx1,
    input  logic [reg_idx_width-1:0] rd_idx2,
    output logic [data_width-1:0]    rd_value1,
    output logic [data_width-1:0]    rd_value2,
    output logic                     rd_busy1,
    output logic                     rd_busy2,
    output logic [rob_tag_width-1:0] rd_tag1,
    output logic [rob_tag_width-1:0] rd_tag2,
    // destination rename
    input  logic                     rename_valid,
    input  logic [reg_idx_width-1:0] rename_idx,
    input  logic [rob_tag_width-1:0] rename_tag,
    // in-order retire from the reorder buffer
    input  logic                     retire_valid,
    input  logic [reg_idx_width-1:0] retire_idx,
    input  logic [rob_tag_width-1:0] retire_tag,
    input  logic [data_width-1:0]    retire_value
);

    // committed value, newest producer tag, busy flag
    logic [data_width-1:0]    reg_value [reg_count];
    logic [rob_tag_width-1:0] reg_tag   [reg_count];
    logic [reg_count-1:0]     reg_busy;

    logic retire_wr;
    logic rename_wr;

    // r0 is never written or renamed
    assign retire_wr = retire_valid && (retire_idx != '0);
    assign rename_wr = rename_valid && (rename_idx != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < reg_count; i++) begin
                reg_value[i] <= '0;
                reg_tag[i]   <= '0;
            end
            reg_busy <= '0;
        end else begin
            if (retire_wr) begin
                reg_value[retire_idx] <= retire_value;
                // older producer must not clear a newer rename
                if (retire_tag == reg_tag[retire_idx]) begin
                    reg_busy[retire_idx] <= 1'b0;
                end
            end
            // rename last so it wins on the same register
            if (rename_wr) begin
                reg_tag[rename_idx]  <= rename_tag;
                reg_busy[rename_idx] <= 1'b1;
            end
        end
    end

    // combinational read ports
    assign rd_value1 = reg_value[rd_idx1];
    assign rd_value2 = reg_value[rd_idx2];
    assign rd_busy1  = reg_busy[rd_idx1];
    assign rd_busy2  = reg_busy[rd_idx2];
    assign rd_tag1   = reg_tag[rd_idx1];
    assign rd_tag2   = reg_tag[rd_idx2];

endmodule

`default_nettype wire

//--- logic/reorder_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module reorder_buffer import ooo_core_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    // allocation from rename
    input  logic                     alloc_valid,
    input  logic [reg_idx_width-1:0] alloc_idx,
    output logic [rob_tag_width-1:0] alloc_tag,
    // out-of-order writeback
    input  logic                     wb_valid,
    input  logic [rob_tag_width-1:0] wb_tag,
    input  logic [data_width-1:0]    wb_value,
    // operand lookups
    input  logic [rob_tag_width-1:0] query_tag1,
    input  logic [rob_tag_width-1:0] query_tag2,
    output logic                     query_ready1,
    output logic                     query_ready2,
    output logic [data_width-1:0]    query_value1,
    output logic [data_width-1:0]    query_value2,
    // registered retire port
    output logic                     retire_valid,
    output logic [reg_idx_width-1:0] retire_idx,
    output logic [rob_tag_width-1:0] retire_tag,
    output logic [data_width-1:0]    retire_value
);

    // per-entry destination, value and ready flag
    logic [reg_idx_width-1:0] entry_idx   [rob_depth];
    logic [data_width-1:0]    entry_value [rob_depth];
    logic [rob_depth-1:0]     entry_ready;

    // circular pointers, count needs one extra bit for full
    logic [rob_tag_width-1:0] head;
    logic [rob_tag_width-1:0] tail;
    logic [rob_tag_width:0]   count;
    logic                     retire_now;

    // head leaves once it holds a result
    assign retire_now = (count != '0) && entry_ready[head];

    // new tag is simply the tail slot
    assign alloc_tag = tail;

    always_ff @(posedge clk) begin
        if (rst) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            entry_ready  <= '0;
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= retire_now;
            if (wb_valid) begin
                entry_ready[wb_tag] <= 1'b1;
            end
            // ready stays set after retire until the slot is reused,
            // covers the cycle where the retire is still in flight
            if (alloc_valid) begin
                entry_ready[tail] <= 1'b0;
                tail              <= tail + 1'b1;
            end
            if (retire_now) begin
                head <= head + 1'b1;
            end
            case ({alloc_valid, retire_now})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_valid) begin
            entry_idx[tail] <= alloc_idx;
        end
        if (wb_valid) begin
            entry_value[wb_tag] <= wb_value;
        end
        // retire payload, qualified by retire_valid
        if (retire_now) begin
            retire_idx   <= entry_idx[head];
            retire_tag   <= head;
            retire_value <= entry_value[head];
        end
    end

    // lookups read the registered state only
    assign query_ready1 = entry_ready[query_tag1];
    assign query_ready2 = entry_ready[query_tag2];
    assign query_value1 = entry_value[query_tag1];
    assign query_value2 = entry_value[query_tag2];

endmodule

`default_nettype wire

//--- logic/rename_issue.sv
`timescale 1ns/10ps
`default_nettype none

module rename_issue import ooo_core_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     instr_valid,
    input  instr_word_t              instr,
    input  logic                     wb_valid,
    input  logic [rob_tag_width-1:0] wb_tag,
    input  logic [data_width-1:0]    wb_value,
    // reorder buffer allocation and lookups
    output logic                     alloc_valid,
    output logic [reg_idx_width-1:0] alloc_idx,
    input  logic [rob_tag_width-1:0] alloc_tag,
    output logic [rob_tag_width-1:0] query_tag1,
    output logic [rob_tag_width-1:0] query_tag2,
    input  logic                     query_ready1,
    input  logic                     query_ready2,
    input  logic [data_width-1:0]    query_value1,
    input  logic [data_width-1:0]    query_value2,
    // register file reads and rename
    output logic [reg_idx_width-1:0] rd_idx1,
    output logic [reg_idx_width-1:0] rd_idx2,
    input  logic [data_width-1:0]    rd_value1,
    input  logic [data_width-1:0]    rd_value2,
    input  logic                     rd_busy1,
    input  logic                     rd_busy2,
    input  logic [rob_tag_width-1:0] rd_tag1,
    input  logic [rob_tag_width-1:0] rd_tag2,
    output logic                     rename_valid,
    output logic [reg_idx_width-1:0] rename_idx,
    output logic [rob_tag_width-1:0] rename_tag,
    // dispatch record
    output logic                     disp_valid,
    output logic [op_width-1:0]      disp_op,
    output logic [rob_tag_width-1:0] disp_tag,
    output logic                     disp_src1_ready,
    output logic [data_width-1:0]    disp_src1_value,
    output logic [rob_tag_width-1:0] disp_src1_tag,
    output logic                     disp_src2_ready,
    output logic [data_width-1:0]    disp_src2_value,
    output logic [rob_tag_width-1:0] disp_src2_tag
);

    logic                     is_imm;
    logic [reg_idx_width-1:0] dst;
    logic [data_width-1:0]    imm_ext;
    logic [data_width:0]      src1_res;
    logic [data_width:0]      src2_res;

    // returns {ready, value}, priority follows the resolution order
    function automatic logic [data_width:0] resolve(
        input logic [reg_idx_width-1:0] idx,
        input logic                     busy,
        input logic [rob_tag_width-1:0] tag,
        input logic [data_width-1:0]    rf_value,
        input logic                     rob_ready,
        input logic [data_width-1:0]    rob_value,
        input logic                     fwd_valid,
        input logic [rob_tag_width-1:0] fwd_tag,
        input logic [data_width-1:0]    fwd_value
    );
        logic [data_width:0] res;
        if (idx == '0) begin
            res = {1'b1, {data_width{1'b0}}};
        end else if (!busy) begin
            res = {1'b1, rf_value};
        end else if (rob_ready) begin
            res = {1'b1, rob_value};
        end else if (fwd_valid && (fwd_tag == tag)) begin
            // same-cycle writeback bypass
            res = {1'b1, fwd_value};
        end else begin
            res = {1'b0, {data_width{1'b0}}};
        end
        return res;
    endfunction

    // opcode msb picks the decoding, common fields overlap
    assign is_imm  = instr.reg_form.op[op_width-1];
    assign dst     = instr.reg_form.dst;
    assign imm_ext = {{(data_width - imm_width){instr.imm_form.imm[imm_width-1]}},
                      instr.imm_form.imm};

    assign rd_idx1    = instr.reg_form.src1;
    assign rd_idx2    = instr.reg_form.src2;
    assign query_tag1 = rd_tag1;
    assign query_tag2 = rd_tag2;

    // every instruction takes an entry, even with r0 as destination
    assign alloc_valid  = instr_valid;
    assign alloc_idx    = dst;
    assign rename_valid = instr_valid && (dst != '0);
    assign rename_idx   = dst;
    assign rename_tag   = alloc_tag;

    assign src1_res = resolve(rd_idx1, rd_busy1, rd_tag1, rd_value1, query_ready1,
                              query_value1, wb_valid, wb_tag, wb_value);
    assign src2_res = is_imm ? {1'b1, imm_ext}
                             : resolve(rd_idx2, rd_busy2, rd_tag2, rd_value2, query_ready2,
                                       query_value2, wb_valid, wb_tag, wb_value);

    always_ff @(posedge clk) begin
        if (rst) begin
            disp_valid <= 1'b0;
        end else begin
            disp_valid <= instr_valid;
        end
    end

    // tag fields only mean something while not ready
    always_ff @(posedge clk) begin
        if (instr_valid) begin
            disp_op         <= instr.reg_form.op;
            disp_tag        <= alloc_tag;
            disp_src1_ready <= src1_res[data_width];
            disp_src1_value <= src1_res[data_width-1:0];
            disp_src1_tag   <= src1_res[data_width] ? '0 : rd_tag1;
            disp_src2_ready <= src2_res[data_width];
            disp_src2_value <= src2_res[data_width-1:0];
            disp_src2_tag   <= src2_res[data_width] ? '0 : rd_tag2;
        end
    end

endmodule

`default_nettype wire

//--- logic/ooo_core_top.sv
`timescale 1ns/10ps
`default_nettype none

module ooo_core_top import ooo_core_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    // credit-based instruction entry
    input  logic                     instr_valid,
    input  instr_word_t              instr,
    // writeback from execution
    input  logic                     wb_valid,
    input  logic [rob_tag_width-1:0] wb_tag,
    input  logic [data_width-1:0]    wb_value,
    // dispatch record
    output logic                     disp_valid,
    output logic [op_width-1:0]      disp_op,
    output logic [rob_tag_width-1:0] disp_tag,
    output logic                     disp_src1_ready,
    output logic [data_width-1:0]    disp_src1_value,
    output logic [rob_tag_width-1:0] disp_src1_tag,
    output logic                     disp_src2_ready,
    output logic [data_width-1:0]    disp_src2_value,
    output logic [rob_tag_width-1:0] disp_src2_tag,
    // commit and credit return
    output logic                     commit_valid,
    output logic [reg_idx_width-1:0] commit_idx,
    output logic [rob_tag_width-1:0] commit_tag,
    output logic [data_width-1:0]    commit_value,
    output logic                     credit_return
);

    // rename to reorder buffer
    logic                     alloc_valid;
    logic [reg_idx_width-1:0] alloc_idx;
    logic [rob_tag_width-1:0] alloc_tag;
    logic [rob_tag_width-1:0] query_tag1;
    logic [rob_tag_width-1:0] query_tag2;
    logic                     query_ready1;
    logic                     query_ready2;
    logic [data_width-1:0]    query_value1;
    logic [data_width-1:0]    query_value2;

    // rename to register file
    logic [reg_idx_width-1:0] rd_idx1;
    logic [reg_idx_width-1:0] rd_idx2;
    logic [data_width-1:0]    rd_value1;
    logic [data_width-1:0]    rd_value2;
    logic                     rd_busy1;
    logic                     rd_busy2;
    logic [rob_tag_width-1:0] rd_tag1;
    logic [rob_tag_width-1:0] rd_tag2;
    logic                     rename_valid;
    logic [reg_idx_width-1:0] rename_idx;
    logic [rob_tag_width-1:0] rename_tag;

    // reorder buffer to register file
    logic                     retire_valid;
    logic [reg_idx_width-1:0] retire_idx;
    logic [rob_tag_width-1:0] retire_tag;
    logic [data_width-1:0]    retire_value;

    // names line up across blocks
    rename_issue   u_rename_issue (.*);
    reorder_buffer u_reorder_buffer (.*);
    reg_file       u_reg_file (.*);

    // each retire is a commit and returns one credit
    assign commit_valid  = retire_valid;
    assign commit_idx    = retire_idx;
    assign commit_tag    = retire_tag;
    assign commit_value  = retire_value;
    assign credit_return = retire_valid;

endmodule

`default_nettype wire

//--- verif/ooo_core_tb.sv
`timescale 1ns/10ps
`default_nettype none

module ooo_core_tb import ooo_core_pkg::*; ();

    localparam int random_cycles = 300;
    // upper bound on instructions over all tests
    localparam int max_instr     = random_cycles + 40;
    // about twenty cycles per instruction and per writeback
    localparam int cycle_limit   = 20 * 2 * max_instr;

    logic                     clk;
    logic                     rst;
    logic                     instr_valid;
    instr_word_t              instr;
    logic                     wb_valid;
    logic [rob_tag_width-1:0] wb_tag;
    logic [data_width-1:0]    wb_value;
    logic                     disp_valid;
    logic [op_width-1:0]      disp_op;
    logic [rob_tag_width-1:0] disp_tag;
    logic                     disp_src1_ready;
    logic [data_width-1:0]    disp_src1_value;
    logic [rob_tag_width-1:0] disp_src1_tag;
    logic                     disp_src2_ready;
    logic [data_width-1:0]    disp_src2_value;
    logic [rob_tag_width-1:0] disp_src2_tag;
    logic                     commit_valid;
    logic [reg_idx_width-1:0] commit_idx;
    logic [rob_tag_width-1:0] commit_tag;
    logic [data_width-1:0]    commit_value;
    logic                     credit_return;

    // source side bookkeeping
    int                       credits;
    int                       cycle_count = 0;
    logic [rob_tag_width-1:0] next_tag;
    logic [rob_tag_width-1:0] pool [$];
    string                    test_name;

    // reference model of what a reader of each register sees
    logic [data_width-1:0]    spec_val [reg_count];
    logic [rob_tag_width-1:0] newest   [reg_count];
    logic [reg_count-1:0]     waiting;
    // reference model of the reorder buffer slots in allocation order
    logic [reg_idx_width-1:0] ent_idx  [rob_depth];
    logic [data_width-1:0]    ent_val  [rob_depth];
    logic [rob_depth-1:0]     ent_ready;
    logic [rob_tag_width-1:0] rob_q [$];
    logic [rob_tag_width-1:0] model_tag;
    logic [rob_tag_width-1:0] ret_tag;

    // expected outputs lined up with the registered DUT outputs
    logic                     exp_disp_valid;
    logic [op_width-1:0]      exp_op;
    logic [rob_tag_width-1:0] exp_tag;
    logic                     exp_src1_ready;
    logic [data_width-1:0]    exp_src1_value;
    logic [rob_tag_width-1:0] exp_src1_tag;
    logic                     exp_src2_ready;
    logic [data_width-1:0]    exp_src2_value;
    logic [rob_tag_width-1:0] exp_src2_tag;
    logic                     exp_commit_valid;
    logic [reg_idx_width-1:0] exp_commit_idx;
    logic [rob_tag_width-1:0] exp_commit_tag;
    logic [data_width-1:0]    exp_commit_value;

    ooo_core_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic report_mismatch(input string field, input logic [data_width-1:0] expected,
                                   input logic [data_width-1:0] actual);
        fail_run($sformatf("mismatch: test %s, %s expected %0h, actual %0h",
                           test_name, field, expected, actual));
    endtask

    function automatic instr_word_t reg_instr(input logic [op_width-1:0] op,
            input logic [reg_idx_width-1:0] dst, input logic [reg_idx_width-1:0] src1,
            input logic [reg_idx_width-1:0] src2);
        instr_word_t w;
        w = '0;
        w.reg_form.op   = op;
        w.reg_form.dst  = dst;
        w.reg_form.src1 = src1;
        w.reg_form.src2 = src2;
        return w;
    endfunction

    function automatic instr_word_t imm_instr(input logic [op_width-1:0] op,
            input logic [reg_idx_width-1:0] dst, input logic [reg_idx_width-1:0] src1,
            input logic [imm_width-1:0] imm);
        instr_word_t w;
        w = '0;
        w.imm_form.op   = op;
        w.imm_form.dst  = dst;
        w.imm_form.src1 = src1;
        w.imm_form.imm  = imm;
        return w;
    endfunction

    // small register range so dependencies and r0 show up often
    function automatic instr_word_t random_instr();
        logic [op_width-1:0] op;
        instr_word_t         w;
        case ($urandom_range(5))
            0:       op = op_add;
            1:       op = op_sub;
            2:       op = op_and;
            3:       op = op_or;
            4:       op = op_addi;
            default: op = op_ori;
        endcase
        if (op[op_width-1]) begin
            w = imm_instr(op, $urandom_range(7), $urandom_range(7), $urandom_range(16383));
        end else begin
            w = reg_instr(op, $urandom_range(7), $urandom_range(7), $urandom_range(7));
        end
        return w;
    endfunction

    // one clock of stimulus
    // wb_mode picks no writeback (0), a random unwritten tag (1) or the oldest one (2)
    task automatic step(input bit do_issue, input int wb_mode, input instr_word_t word);
        int pick;
        @(posedge clk);
        // pulse seen in the cycle just ended
        if (credit_return) begin
            credits++;
        end
        instr_valid <= 1'b0;
        wb_valid    <= 1'b0;
        // only tags issued in earlier cycles are eligible
        if (wb_mode != 0 && pool.size() > 0) begin
            pick = (wb_mode == 1) ? $urandom_range(pool.size() - 1) : 0;
            wb_valid <= 1'b1;
            wb_tag   <= pool[pick];
            wb_value <= $urandom;
            pool.delete(pick);
        end
        if (do_issue && credits > 0) begin
            instr_valid <= 1'b1;
            instr       <= word;
            credits--;
            pool.push_back(next_tag);
            next_tag++;
        end
    endtask

    // write back everything and wait for every credit
    task automatic drain();
        while (pool.size() > 0 || credits != rob_depth) begin
            step(0, 1, '0);
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < reg_count; i++) begin
                spec_val[i] = '0;
                newest[i]   = '0;
            end
            waiting   = '0;
            ent_ready = '0;
            rob_q.delete();
            model_tag = '0;
            exp_disp_valid   <= 1'b0;
            exp_commit_valid <= 1'b0;
        end else begin
            // head leaves if its result arrived before this edge
            exp_commit_valid <= 1'b0;
            if (rob_q.size() > 0 && ent_ready[rob_q[0]]) begin
                ret_tag = rob_q.pop_front();
                exp_commit_valid <= 1'b1;
                exp_commit_tag   <= ret_tag;
                exp_commit_idx   <= ent_idx[ret_tag];
                exp_commit_value <= ent_val[ret_tag];
            end
            // older producers never release a newer rename
            if (wb_valid) begin
                ent_ready[wb_tag] = 1'b1;
                ent_val[wb_tag]   = wb_value;
                if (waiting[ent_idx[wb_tag]] && newest[ent_idx[wb_tag]] == wb_tag) begin
                    waiting[ent_idx[wb_tag]]  = 1'b0;
                    spec_val[ent_idx[wb_tag]] = wb_value;
                end
            end
            exp_disp_valid <= instr_valid;
            if (instr_valid) begin
                exp_op         <= instr.reg_form.op;
                exp_tag        <= model_tag;
                // sources see state before this instruction's own rename
                exp_src1_ready <= !waiting[instr.reg_form.src1];
                exp_src1_value <= spec_val[instr.reg_form.src1];
                exp_src1_tag   <= newest[instr.reg_form.src1];
                if (instr.reg_form.op[op_width-1]) begin
                    exp_src2_ready <= 1'b1;
                    exp_src2_value <= data_width'($signed(instr.imm_form.imm));
                end else begin
                    exp_src2_ready <= !waiting[instr.reg_form.src2];
                    exp_src2_value <= spec_val[instr.reg_form.src2];
                    exp_src2_tag   <= newest[instr.reg_form.src2];
                end
                // every instruction takes a slot but r0 is never renamed
                ent_idx[model_tag]   = instr.reg_form.dst;
                ent_ready[model_tag] = 1'b0;
                rob_q.push_back(model_tag);
                if (instr.reg_form.dst != '0) begin
                    newest[instr.reg_form.dst]  = model_tag;
                    waiting[instr.reg_form.dst] = 1'b1;
                end
                model_tag++;
            end
        end
    end

    // handshake and credit timing
    assert property (@(posedge clk) disable iff (rst) disp_valid == exp_disp_valid)
        else report_mismatch("disp_valid", $sampled(exp_disp_valid), $sampled(disp_valid));
    assert property (@(posedge clk) disable iff (rst) commit_valid == exp_commit_valid)
        else report_mismatch("commit_valid", $sampled(exp_commit_valid), $sampled(commit_valid));
    assert property (@(posedge clk) disable iff (rst) credit_return == exp_commit_valid)
        else report_mismatch("credit_return", $sampled(exp_commit_valid),
                             $sampled(credit_return));

    // dispatch record
    assert property (@(posedge clk) disable iff (rst) disp_valid |-> disp_op == exp_op)
        else report_mismatch("disp_op", $sampled(exp_op), $sampled(disp_op));
    assert property (@(posedge clk) disable iff (rst) disp_valid |-> disp_tag == exp_tag)
        else report_mismatch("disp_tag", $sampled(exp_tag), $sampled(disp_tag));
    assert property (@(posedge clk) disable iff (rst)
            disp_valid |-> disp_src1_ready == exp_src1_ready)
        else report_mismatch("src1_ready", $sampled(exp_src1_ready), $sampled(disp_src1_ready));
    assert property (@(posedge clk) disable iff (rst)
            disp_valid && exp_src1_ready |-> disp_src1_value == exp_src1_value)
        else report_mismatch("src1_value", $sampled(exp_src1_value), $sampled(disp_src1_value));
    assert property (@(posedge clk) disable iff (rst)
            disp_valid && !exp_src1_ready |-> disp_src1_tag == exp_src1_tag)
        else report_mismatch("src1_tag", $sampled(exp_src1_tag), $sampled(disp_src1_tag));
    assert property (@(posedge clk) disable iff (rst)
            disp_valid |-> disp_src2_ready == exp_src2_ready)
        else report_mismatch("src2_ready", $sampled(exp_src2_ready), $sampled(disp_src2_ready));
    assert property (@(posedge clk) disable iff (rst)
            disp_valid && exp_src2_ready |-> disp_src2_value == exp_src2_value)
        else report_mismatch("src2_value", $sampled(exp_src2_value), $sampled(disp_src2_value));
    assert property (@(posedge clk) disable iff (rst)
            disp_valid && !exp_src2_ready |-> disp_src2_tag == exp_src2_tag)
        else report_mismatch("src2_tag", $sampled(exp_src2_tag), $sampled(disp_src2_tag));

    // commit payload in allocation order
    assert property (@(posedge clk) disable iff (rst) commit_valid |-> commit_tag == exp_commit_tag)
        else report_mismatch("commit_tag", $sampled(exp_commit_tag), $sampled(commit_tag));
    assert property (@(posedge clk) disable iff (rst) commit_valid |-> commit_idx == exp_commit_idx)
        else report_mismatch("commit_idx", $sampled(exp_commit_idx), $sampled(commit_idx));
    assert property (@(posedge clk) disable iff (rst)
            commit_valid |-> commit_value == exp_commit_value)
        else report_mismatch("commit_value", $sampled(exp_commit_value), $sampled(commit_value));

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            fail_run("timeout, the run did not finish within the cycle limit");
        end
    end

    initial begin
        void'($urandom(32'h578d_c4ae));
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        wb_valid    = 1'b0;
        wb_tag      = '0;
        wb_value    = '0;
        credits     = rob_depth;
        next_tag    = '0;
        test_name   = "reset";
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        // quiet outputs until the first instruction
        repeat (4) step(0, 0, '0);
        step(1, 0, reg_instr(op_add, 1, 2, 3));
        // first dispatch carries tag 0 on both ready sources
        step(0, 0, '0);
        @(negedge clk);
        assert (disp_src1_tag == '0)
            else report_mismatch("src1_tag", '0, disp_src1_tag);
        assert (disp_src2_tag == '0)
            else report_mismatch("src2_tag", '0, disp_src2_tag);
        drain();

        test_name = "credit_limit";
        repeat (rob_depth) step(1, 0, random_instr());
        // source holds back since nothing retires without writebacks
        repeat (6) step(1, 0, random_instr());
        drain();
        repeat (rob_depth) step(1, 1, random_instr());
        drain();

        test_name = "renaming";
        step(1, 0, reg_instr(op_add, 5, 1, 2));
        step(1, 0, reg_instr(op_sub, 5, 3, 4));
        // only the older producer of r5 completes
        step(0, 2, '0);
        while (credits != rob_depth - 1) begin
            step(0, 0, '0);
        end
        step(1, 0, reg_instr(op_or, 6, 5, 0));
        // newer producer written back in the same cycle as the read
        step(1, 2, reg_instr(op_and, 7, 5, 5));
        drain();
        // committed by now so the value comes from the register file
        step(1, 0, reg_instr(op_add, 8, 5, 6));
        drain();

        test_name = "r0_and_imm";
        step(1, 0, imm_instr(op_addi, 0, 0, 14'h2abc));
        step(1, 1, reg_instr(op_or, 0, 0, 0));
        step(1, 1, imm_instr(op_ori, 3, 0, 14'h1fff));
        step(1, 1, imm_instr(op_addi, 4, 0, 14'h3fff));
        step(1, 1, reg_instr(op_add, 9, 0, 4));
        step(1, 1, reg_instr(op_sub, 10, 3, 0));
        drain();

        test_name = "random";
        repeat (random_cycles) step($urandom_range(3) != 0, $urandom_range(1), random_instr());
        drain();

        test_name = "end";
        repeat (4) step(0, 0, '0);
        if (credits == rob_depth && pool.size() == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            fail_run("credits or writebacks still outstanding at the end of the run");
        end
    end

endmodule

`default_nettype wire

//--- project.f
logic/ooo_core_pkg.sv
logic/reg_file.sv
logic/reorder_buffer.sv
logic/rename_issue.sv
logic/ooo_core_top.sv
verif/ooo_core_tb.sv

//--- Bender.yml
package:
  name: ooo_core

sources:
  - logic/ooo_core_pkg.sv
  - logic/reg_file.sv
  - logic/reorder_buffer.sv
  - logic/rename_issue.sv
  - logic/ooo_core_top.sv
  - target: test
    files:
      - verif/ooo_core_tb.sv
